//--- gtp_test_defines.svh
`ifndef GTP_TEST_DEFINES_SVH
`define GTP_TEST_DEFINES_SVH

// word widths
`define SER_WIDTH 8
`define LANE_WIDTH 16

// counter bit that lets the serializer go, the next one up lets the generator go
`define RESET_PICKOFF 4

// clean words in a row before the sma checker calls lock
`define LOCK_WORDS 4

// free-running counter taps for the gpio pair, kept low so sim sees them move
`define GPIO_LO_BIT 5
`define GPIO_HI_BIT 9

// generator state out of reset
`define PRBS_SEED 7'h7F

`endif

//--- gtp_test_pkg.sv
`include "gtp_test_defines.svh"

package gtp_test_pkg;

	typedef logic [`SER_WIDTH-1:0]  ser_word_t;   // one word into the serializer
	typedef logic [`LANE_WIDTH-1:0] lane_word_t;  // one transceiver word
	typedef logic [6:0]             prbs_state_t; // x^7 + x^6 + 1 register
	typedef logic [7:0]             err_count_t;  // saturates at 255

	// sma receive checker
	// SEARCH counts clean words, LOST waits for one clean word before searching again
	typedef enum logic [1:0] {
		SEARCH,
		LOCKED,
		LOST
	} mon_state_e;

endpackage

//--- reset_sequencer.sv
`include "gtp_test_defines.svh"

module reset_sequencer (
	input  logic other_word_clock,
	input  logic arst_n,
	output logic ser_rst,
	output logic gen_rst
);

	logic [`RESET_PICKOFF+1:0] rst_cnt;
	logic [`RESET_PICKOFF+1:0] rst_cnt_next;

	assign rst_cnt_next = rst_cnt + 1'b1;

	// stages drop out in order as the pick-off bits first set
	always_ff @(posedge other_word_clock or negedge arst_n) begin
		if (!arst_n) begin
			rst_cnt <= '0;
			ser_rst <= 1'b1;
			gen_rst <= 1'b1;
		end else if (gen_rst) begin // counter parks once the last stage is free
			rst_cnt <= rst_cnt_next;
			if (rst_cnt_next[`RESET_PICKOFF]) begin
				ser_rst <= 1'b0; // serializer first, 16 clocks in
			end
			if (rst_cnt_next[`RESET_PICKOFF+1]) begin
				gen_rst <= 1'b0; // then the generator and the rest
			end
		end
	end

	// serializer must be out of reset before anything upstream can run
	a_reset_order : assert property (
		@(posedge other_word_clock) disable iff (!arst_n)
		ser_rst |-> gen_rst
	);

endmodule

//--- prbs_word_gen.sv
`include "gtp_test_defines.svh"

module prbs_word_gen
	import gtp_test_pkg::*;
(
	input  logic      other_word_clock,
	input  logic      arst_n,
	input  logic      gen_rst,
	output ser_word_t word,
	output logic      word_strobe
);

	localparam int PHASE_W = $clog2(`SER_WIDTH);

	prbs_state_t        prbs_state;
	prbs_state_t        prbs_state_next;
	ser_word_t          word_next;
	logic [PHASE_W-1:0] phase;

	// run the lfsr forward one word, first bit out lands in the msb
	always_comb begin
		prbs_state_t s;
		logic        b;
		s = prbs_state;
		word_next = '0;
		for (int i = 0; i < `SER_WIDTH; i++) begin
			b = s[6] ^ s[5];
			s = {s[5:0], b};
			word_next = {word_next[`SER_WIDTH-2:0], b};
		end
		prbs_state_next = s;
	end

	always_ff @(posedge other_word_clock or negedge arst_n) begin
		if (!arst_n) begin
			prbs_state  <= `PRBS_SEED;
			phase       <= '0;
			word_strobe <= 1'b0;
		end else if (gen_rst) begin
			prbs_state  <= `PRBS_SEED;
			phase       <= '0;
			word_strobe <= 1'b0;
		end else begin
			phase       <= phase + 1'b1;  // wraps every word
			word_strobe <= (phase == '0);
			if (phase == '0) begin
				prbs_state <= prbs_state_next;
			end
		end
	end

	always_ff @(posedge other_word_clock) begin
		if (!gen_rst && phase == '0) begin
			word <= word_next; // valid alongside the strobe
		end
	end

	a_strobe_single : assert property (
		@(posedge other_word_clock) disable iff (!arst_n)
		word_strobe |=> !word_strobe
	);

endmodule

//--- word_serializer.sv
`include "gtp_test_defines.svh"

module word_serializer
	import gtp_test_pkg::*;
(
	input  logic      other_word_clock,
	input  logic      arst_n,
	input  logic      ser_rst,
	input  ser_word_t word,
	input  logic      word_strobe,
	output logic      serial_bit
);

	ser_word_t shreg;

	// stands in for the oserdes, msb goes out first
	always_ff @(posedge other_word_clock or negedge arst_n) begin
		if (!arst_n) begin
			shreg <= '0;
		end else if (ser_rst) begin
			shreg <= '0;
		end else if (word_strobe) begin
			shreg <= word;
		end else begin
			shreg <= {shreg[`SER_WIDTH-2:0], 1'b0};
		end
	end

	assign serial_bit = shreg[`SER_WIDTH-1];

	// the generator is released after us, so a strobe here would be lost
	a_no_strobe_in_reset : assert property (
		@(posedge other_word_clock) disable iff (!arst_n)
		word_strobe |-> !ser_rst
	);

endmodule

//--- lane_exchange_monitor.sv
`include "gtp_test_defines.svh"

module lane_exchange_monitor
	import gtp_test_pkg::*;
(
	input  logic       other_word_clock,
	input  logic       arst_n,
	input  logic       gen_rst,
	input  lane_word_t sma_rx,
	input  lane_word_t sfp_rx,
	output lane_word_t sma_tx,
	output lane_word_t sfp_tx,
	output logic       prbs_lock,
	output err_count_t error_count
);

	localparam int CLEAN_W = $clog2(`LOCK_WORDS + 1);

	mon_state_e         mon_state;
	prbs_state_t        hist;
	prbs_state_t        hist_next;
	logic               word_bad;
	logic               primed;
	logic [CLEAN_W-1:0] clean_cnt;

	// lane crossover, one register each way
	always_ff @(posedge other_word_clock or negedge arst_n) begin
		if (!arst_n) begin
			sma_tx <= '0;
			sfp_tx <= '0;
		end else begin
			sfp_tx <= sma_rx;
			sma_tx <= sfp_rx;
		end
	end

	// checker works on the registered sma word, msb first
	// all-zero history is the lfsr lockup state and never valid
	always_comb begin
		prbs_state_t h;
		logic        pred;
		h = hist;
		word_bad = 1'b0;
		for (int i = `LANE_WIDTH-1; i >= 0; i--) begin
			pred = h[6] ^ h[5];
			if (sfp_tx[i] != pred || h == '0) begin
				word_bad = 1'b1;
			end
			h = {h[5:0], sfp_tx[i]};
		end
		hist_next = h;
	end

	always_ff @(posedge other_word_clock) begin
		hist <= hist_next; // reloaded from received bits every word
	end

	always_ff @(posedge other_word_clock or negedge arst_n) begin
		if (!arst_n) begin
			mon_state   <= SEARCH;
			primed      <= 1'b0;
			clean_cnt   <= '0;
			error_count <= '0;
		end else if (gen_rst) begin
			mon_state <= SEARCH;
			primed    <= 1'b0;
			clean_cnt <= '0;
		end else if (!primed) begin
			primed <= 1'b1; // first word only fills history
		end else begin
			case (mon_state)
				SEARCH: begin
					if (word_bad) begin
						clean_cnt <= '0;
					end else if (clean_cnt == CLEAN_W'(`LOCK_WORDS - 1)) begin
						clean_cnt <= '0;
						mon_state <= LOCKED;
					end else begin
						clean_cnt <= clean_cnt + 1'b1;
					end
				end
				LOCKED: begin
					if (word_bad) begin
						mon_state <= LOST;
						if (error_count != '1) begin
							error_count <= error_count + 1'b1; // saturate
						end
					end
				end
				LOST: begin
					if (!word_bad) begin
						mon_state <= SEARCH;
					end
				end
				default: mon_state <= SEARCH;
			endcase
		end
	end

	assign prbs_lock = (mon_state == LOCKED);

	// a locked checker never holds the lfsr lockup state
	a_lock_hist_live : assert property (
		@(posedge other_word_clock) disable iff (!arst_n)
		prbs_lock |-> (hist != '0)
	);

endmodule

//--- status_outputs.sv
`include "gtp_test_defines.svh"

module status_outputs
	import gtp_test_pkg::*;
(
	input  logic       other_word_clock,
	input  logic       arst_n,
	input  logic       gen_rst,
	input  ser_word_t  word,
	input  logic       word_strobe,
	output logic [3:0] leds,
	output logic       gpio_p,
	output logic       gpio_n
);

	logic [`GPIO_HI_BIT:0] free_cnt;

	always_ff @(posedge other_word_clock or negedge arst_n) begin
		if (!arst_n) begin
			free_cnt <= '0;
		end else begin
			free_cnt <= free_cnt + 1'b1; // never stops
		end
	end

	assign gpio_p = free_cnt[`GPIO_LO_BIT];
	assign gpio_n = free_cnt[`GPIO_HI_BIT];

	// low nibble of each generated word
	always_ff @(posedge other_word_clock or negedge arst_n) begin
		if (!arst_n) begin
			leds <= '0;
		end else if (gen_rst) begin
			leds <= '0;
		end else if (word_strobe) begin
			leds <= word[3:0];
		end
	end

endmodule

//--- gtp_test_top.sv
module gtp_test_top
	import gtp_test_pkg::*;
(
	input  logic       other_word_clock,
	input  logic       arst_n,
	input  lane_word_t sma_rx,
	input  lane_word_t sfp_rx,
	output lane_word_t sma_tx,
	output lane_word_t sfp_tx,
	output logic       serial_bit,
	output logic [3:0] leds,
	output logic       gpio_p,
	output logic       gpio_n,
	output logic       prbs_lock,
	output err_count_t error_count
);

	logic      ser_rst;
	logic      gen_rst;
	ser_word_t word;
	logic      word_strobe;

	reset_sequencer u_reset_sequencer (
		.other_word_clock (other_word_clock),
		.arst_n           (arst_n),
		.ser_rst          (ser_rst),
		.gen_rst          (gen_rst)
	);

	prbs_word_gen u_prbs_word_gen (
		.other_word_clock (other_word_clock),
		.arst_n           (arst_n),
		.gen_rst          (gen_rst),
		.word             (word),
		.word_strobe      (word_strobe)
	);

	word_serializer u_word_serializer (
		.other_word_clock (other_word_clock),
		.arst_n           (arst_n),
		.ser_rst          (ser_rst),
		.word             (word),
		.word_strobe      (word_strobe),
		.serial_bit       (serial_bit)
	);

	lane_exchange_monitor u_lane_exchange_monitor (
		.other_word_clock (other_word_clock),
		.arst_n           (arst_n),
		.gen_rst          (gen_rst),
		.sma_rx           (sma_rx),
		.sfp_rx           (sfp_rx),
		.sma_tx           (sma_tx),
		.sfp_tx           (sfp_tx),
		.prbs_lock        (prbs_lock),
		.error_count      (error_count)
	);

	status_outputs u_status_outputs (
		.other_word_clock (other_word_clock),
		.arst_n           (arst_n),
		.gen_rst          (gen_rst),
		.word             (word),
		.word_strobe      (word_strobe),
		.leds             (leds),
		.gpio_p           (gpio_p),
		.gpio_n           (gpio_n)
	);

endmodule

//--- tb_gtp_test.sv
`include "gtp_test_defines.svh"

module tb_gtp_test
	import gtp_test_pkg::*;
();

	logic       other_word_clock;
	logic       arst_n;
	lane_word_t sma_rx;
	lane_word_t sfp_rx;
	lane_word_t sma_tx;
	lane_word_t sfp_tx;
	logic       serial_bit;
	logic [3:0] leds;
	logic       gpio_p;
	logic       gpio_n;
	logic       prbs_lock;
	err_count_t error_count;

	logic [15:0] rnd_state; // galois lfsr for random lane words
	prbs_state_t tx_prbs;   // reference stream into sma_rx

	gtp_test_top UUT (
		.other_word_clock (other_word_clock),
		.arst_n           (arst_n),
		.sma_rx           (sma_rx),
		.sfp_rx           (sfp_rx),
		.sma_tx           (sma_tx),
		.sfp_tx           (sfp_tx),
		.serial_bit       (serial_bit),
		.leds             (leds),
		.gpio_p           (gpio_p),
		.gpio_n           (gpio_n),
		.prbs_lock        (prbs_lock),
		.error_count      (error_count)
	);

	always #20 other_word_clock = ~other_word_clock;

	task stop_failed();
		$display("sim failed");
		$fatal(1, "testbench stopped on first error");
	endtask

	task fail_run(input string msg);
		$display("%s", msg);
		stop_failed();
	endtask

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	// galois step, taps 16 14 13 11
	function automatic logic lfsr_step();
		logic b;
		b = rnd_state[0];
		rnd_state = {1'b0, rnd_state[15:1]} ^ (b ? 16'hB400 : 16'h0000);
		return b;
	endfunction

	task random_word(output lane_word_t w);
		for (int i = 0; i < `LANE_WIDTH; i++) begin
			w = {w[`LANE_WIDTH-2:0], lfsr_step()};
		end
	endtask

	// new bit is bit 6 xor bit 5, shifted in at bit 0
	task prbs_bit(inout prbs_state_t s, output logic b);
		b = s[6] ^ s[5];
		s = {s[5:0], b};
	endtask

	task send_clean_word();
		lane_word_t w;
		logic       b;
		for (int i = `LANE_WIDTH-1; i >= 0; i--) begin
			prbs_bit(tx_prbs, b);
			w[i] = b; // first bit in the msb
		end
		sma_rx = w;
	endtask

	task check_idle_outputs();
		check_value("serial_bit", serial_bit, 0);
		check_value("leds", leds, 0);
		check_value("prbs_lock", prbs_lock, 0);
		check_value("error_count", error_count, 0);
		check_value("sma_tx", sma_tx, 0);
		check_value("sfp_tx", sfp_tx, 0);
	endtask

	task check_reset_state();
		repeat (4) begin
			@(negedge other_word_clock);
			check_idle_outputs();
		end
		arst_n = 1'b1;
		@(negedge other_word_clock);
		check_idle_outputs();
	endtask

	task check_crossover();
		lane_word_t prev_sma;
		lane_word_t prev_sfp;
		for (int k = 0; k <= 24; k++) begin
			@(negedge other_word_clock);
			if (k > 0) begin
				check_value("sfp_tx", sfp_tx, prev_sma);
				check_value("sma_tx", sma_tx, prev_sfp);
			end
			if (k < 24) begin
				random_word(prev_sma);
				random_word(prev_sfp);
			end else begin
				prev_sma = '0;
				prev_sfp = '0;
			end
			sma_rx = prev_sma;
			sfp_rx = prev_sfp;
		end
	endtask

	task check_serial_prbs();
		logic        bits [0:70];
		prbs_state_t s;
		logic        b;
		int          first_one;
		int          led_off;
		int          waited;
		// position of the first 1 inside its word, from the seed
		s = `PRBS_SEED;
		first_one = -1;
		for (int i = 0; i < 64; i++) begin
			prbs_bit(s, b);
			if (b && first_one < 0) begin
				first_one = i;
			end
		end
		led_off = `SER_WIDTH - 1 - (first_one % `SER_WIDTH); // bits to end of that word
		waited = 0;
		@(negedge other_word_clock);
		while (serial_bit !== 1'b1) begin
			if (waited == 400) begin
				fail_run("no 1 bit ever appeared on serial_bit");
			end
			waited++;
			@(negedge other_word_clock);
		end
		bits[0] = 1'b1;
		for (int i = 1; i < 71; i++) begin
			@(negedge other_word_clock);
			bits[i] = serial_bit;
			if (i >= 7) begin
				check_value("serial_bit", serial_bit, bits[i-7] ^ bits[i-6]);
			end
			if (i >= 3 && i >= led_off && (i - led_off) % `SER_WIDTH == 0) begin
				check_value("leds", leds, {bits[i-3], bits[i-2], bits[i-1], bits[i]});
			end
		end
	endtask

	task check_lock();
		int sent;
		sent = 0;
		@(negedge other_word_clock);
		check_value("error_count", error_count, 0);
		while (!prbs_lock) begin
			if (sent == `LOCK_WORDS + 2) begin
				fail_run("prbs_lock did not rise on a clean PRBS-7 stream");
			end
			send_clean_word();
			sent++;
			@(negedge other_word_clock);
			check_value("error_count", error_count, 0);
		end
		send_clean_word(); // stream keeps running into the next test
	endtask

	task check_errors();
		int sent;
		@(negedge other_word_clock);
		check_value("prbs_lock", prbs_lock, 1);
		send_clean_word();
		sma_rx[`LANE_WIDTH-1] = ~sma_rx[`LANE_WIDTH-1]; // single bit error
		sent = 0;
		@(negedge other_word_clock);
		while (prbs_lock) begin
			if (sent == 3) begin
				fail_run("prbs_lock stayed high after a bit error");
			end
			send_clean_word();
			sent++;
			@(negedge other_word_clock);
		end
		check_value("error_count", error_count, 1);
		while (!prbs_lock) begin
			if (sent == `LOCK_WORDS + 3) begin
				fail_run("prbs_lock did not return after clean words resumed");
			end
			send_clean_word();
			sent++;
			@(negedge other_word_clock);
			check_value("error_count", error_count, 1);
		end
		send_clean_word();
	endtask

	task check_gpio();
		logic prev;
		@(negedge other_word_clock);
		prev = gpio_p;
		repeat (32) @(negedge other_word_clock);
		check_value("gpio_p", gpio_p, !prev);
		prev = gpio_n;
		repeat (512) @(negedge other_word_clock);
		check_value("gpio_n", gpio_n, !prev);
	endtask

	initial begin
		other_word_clock = 1'b0;
		arst_n = 1'b0;
		sma_rx = '0;
		sfp_rx = '0;
		rnd_state = 16'd61;
		tx_prbs = 7'h2A; // any nonzero start, the checker syncs itself
		check_reset_state();
		check_crossover();
		check_serial_prbs();
		check_lock();
		check_errors();
		check_gpio();
		$display("sim passed");
		$finish;
	end

endmodule

//--- build.f
+incdir+.
gtp_test_pkg.sv
reset_sequencer.sv
prbs_word_gen.sv
word_serializer.sv
lane_exchange_monitor.sv
status_outputs.sv
gtp_test_top.sv
tb_gtp_test.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_gtp_test \
	-Mdir obj_dir -o tb_gtp_test \
	&& ./obj_dir/tb_gtp_test \
	|| { echo "simulation did not pass"; exit 1; }
